/* common/ip_rx_params.svh */
// sizes and check constants of the ipv4 receive parser, included by the package and the rtl
`ifndef IP_RX_PARAMS_SVH
`define IP_RX_PARAMS_SVH

// stream and field widths
`define BYTE_W 8
`define LEN_W 16
`define ADDR_W 32
`define IP_FLAGS_W 3
`define IP_FRAG_W 13

// header layout, no options supported
`define IP_HDR_BYTES 20
`define IP_HDR_IDX_W 5

// required version and ihl
`define IP_VERSION_V4 4'd4
`define IP_IHL_MIN 4'd5

// ones' complement sum over a correct header
`define IP_CSUM_GOOD 16'hffff

`endif

/* common/ip_rx_pkg.sv */
// shared types of the ipv4 receive parser, imported by the rtl and the testbench
`default_nettype none
`include "ip_rx_params.svh"

package ip_rx_pkg;

    typedef logic [`BYTE_W-1:0] byte_t;
    typedef logic [`LEN_W-1:0] ip_len_t;
    typedef logic [`ADDR_W-1:0] ip_addr_t;
    typedef logic [`IP_HDR_IDX_W-1:0] hdr_idx_t;

    // header bytes 6 and 7, flags sit in the top three bits
    typedef union packed {
        ip_len_t raw;
        struct packed {
            logic [`IP_FLAGS_W-1:0] flags;
            logic [`IP_FRAG_W-1:0]  offset;
        } fields;
    } ip_frag_word_u;

    typedef enum logic [2:0] {
        IDLE,
        READ_HEADER,
        READ_PAYLOAD,
        READ_PAYLOAD_LAST,
        WAIT_LAST
    } rx_state_e;

endpackage

`default_nettype wire

/* parser/ip_frame_counter.sv */
// byte pointer over one ipv4 frame, flags the last header byte and the last payload byte
`timescale 1ns/1ps
`default_nettype none
`include "ip_rx_params.svh"

module ip_frame_counter (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cnt_clear,
    input  wire                          cnt_step,
    input  wire ip_rx_pkg::ip_len_t      ip_length,
    output ip_rx_pkg::hdr_idx_t          hdr_idx,
    output logic                         hdr_last,
    output logic                         payload_end
);
    import ip_rx_pkg::*;

    ip_len_t ptr;
    ip_len_t ptr_inc;

    assign ptr_inc = ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (cnt_clear) begin
            ptr <= '0;
        end else if (cnt_step) begin
            ptr <= ptr_inc;
        end
    end

    assign hdr_idx = ptr[`IP_HDR_IDX_W-1:0];
    assign hdr_last = (ptr == ip_len_t'(`IP_HDR_BYTES - 1));
    // ip_length counts the header too
    assign payload_end = (ptr_inc == ip_length);

endmodule

`default_nettype wire

/* parser/ip_hdr_capture.sv */
// ipv4 header field registers written by byte index, with the version and ihl check
`timescale 1ns/1ps
`default_nettype none
`include "ip_rx_params.svh"

module ip_hdr_capture (
    input  wire                          clk,
    input  wire                          capture_en,
    input  wire ip_rx_pkg::hdr_idx_t     hdr_idx,
    input  wire ip_rx_pkg::byte_t        in_tdata,
    output logic [5:0]                   ip_dscp,
    output logic [1:0]                   ip_ecn,
    output ip_rx_pkg::ip_len_t           ip_length,
    output ip_rx_pkg::ip_len_t           ip_identification,
    output logic [`IP_FLAGS_W-1:0]       ip_flags,
    output logic [`IP_FRAG_W-1:0]        ip_fragment_offset,
    output ip_rx_pkg::byte_t             ip_ttl,
    output ip_rx_pkg::byte_t             ip_protocol,
    output ip_rx_pkg::ip_len_t           ip_header_checksum,
    output ip_rx_pkg::ip_addr_t          ip_source_ip,
    output ip_rx_pkg::ip_addr_t          ip_dest_ip,
    output logic                         hdr_fields_ok
);
    import ip_rx_pkg::*;

    logic [3:0]    version;
    logic [3:0]    ihl;
    ip_frag_word_u frag_word;

    // network order, most significant byte first
    always_ff @(posedge clk) begin
        if (capture_en) begin
            case (hdr_idx)
                5'd0:  {version, ihl} <= in_tdata;
                5'd1:  {ip_dscp, ip_ecn} <= in_tdata;
                5'd2:  ip_length[15:8] <= in_tdata;
                5'd3:  ip_length[7:0] <= in_tdata;
                5'd4:  ip_identification[15:8] <= in_tdata;
                5'd5:  ip_identification[7:0] <= in_tdata;
                5'd6:  frag_word.raw[15:8] <= in_tdata;
                5'd7:  frag_word.raw[7:0] <= in_tdata;
                5'd8:  ip_ttl <= in_tdata;
                5'd9:  ip_protocol <= in_tdata;
                5'd10: ip_header_checksum[15:8] <= in_tdata;
                5'd11: ip_header_checksum[7:0] <= in_tdata;
                5'd12: ip_source_ip[31:24] <= in_tdata;
                5'd13: ip_source_ip[23:16] <= in_tdata;
                5'd14: ip_source_ip[15:8] <= in_tdata;
                5'd15: ip_source_ip[7:0] <= in_tdata;
                5'd16: ip_dest_ip[31:24] <= in_tdata;
                5'd17: ip_dest_ip[23:16] <= in_tdata;
                5'd18: ip_dest_ip[15:8] <= in_tdata;
                5'd19: ip_dest_ip[7:0] <= in_tdata;
                default: ;
            endcase
        end
    end

    assign ip_flags = frag_word.fields.flags;
    assign ip_fragment_offset = frag_word.fields.offset;

    // options are not supported, so only ihl 5 passes
    assign hdr_fields_ok = (version == `IP_VERSION_V4) && (ihl == `IP_IHL_MIN);

endmodule

`default_nettype wire

/* parser/ip_hdr_checksum.sv */
// running ones' complement sum over the ipv4 header bytes
`timescale 1ns/1ps
`default_nettype none
`include "ip_rx_params.svh"

module ip_hdr_checksum (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          sum_clear,
    input  wire                          sum_step,
    input  wire ip_rx_pkg::hdr_idx_t     hdr_idx,
    input  wire ip_rx_pkg::byte_t        in_tdata,
    output logic                         sum_ok
);
    import ip_rx_pkg::*;

    ip_len_t         sum;
    ip_len_t         sum_next;
    ip_len_t         addend;
    logic [`LEN_W:0] raw;

    // even index is the high byte of a word
    assign addend = hdr_idx[0] ? {{`BYTE_W{1'b0}}, in_tdata} : {in_tdata, {`BYTE_W{1'b0}}};
    assign raw = sum + addend;
    // end-around carry
    assign sum_next = raw[`LEN_W-1:0] + raw[`LEN_W];

    always_ff @(posedge clk) begin
        if (rst || sum_clear) begin
            sum <= '0;
        end else if (sum_step) begin
            sum <= sum_next;
        end
    end

    assign sum_ok = (sum_next == `IP_CSUM_GOOD);

endmodule

`default_nettype wire

/* parser/ip_rx_fsm.sv */
// frame fsm of the ipv4 parser, steers header capture, checksum, counting and payload
`timescale 1ns/1ps
`default_nettype none

module ip_rx_fsm (
    input  wire                          clk,
    input  wire                          rst,
    input  wire ip_rx_pkg::byte_t        in_tdata,
    input  wire                          in_tvalid,
    output logic                         in_tready,
    input  wire                          in_tlast,
    input  wire                          in_tuser,
    output logic                         hdr_valid,
    input  wire                          hdr_ready,
    input  wire ip_rx_pkg::hdr_idx_t     hdr_idx,
    input  wire                          hdr_last,
    input  wire                          payload_end,
    input  wire                          hdr_fields_ok,
    input  wire                          sum_ok,
    output logic                         cnt_clear,
    output logic                         cnt_step,
    output logic                         capture_en,
    output logic                         sum_clear,
    output logic                         sum_step,
    output ip_rx_pkg::byte_t             int_tdata,
    output logic                         int_tvalid,
    output logic                         int_tlast,
    output logic                         int_tuser,
    input  wire                          int_tready_early,
    output logic                         error_header_early,
    output logic                         error_payload_early,
    output logic                         error_invalid_header,
    output logic                         error_invalid_checksum
);
    import ip_rx_pkg::*;

    rx_state_e state;
    rx_state_e state_next;
    logic      in_fire;
    logic      pkt_end;
    logic      in_tready_next;
    logic      hdr_valid_next;
    logic      hdr_early_next;
    logic      pay_early_next;
    logic      inv_hdr_next;
    logic      inv_csum_next;
    logic      store_last;
    byte_t     last_byte;

    assign in_fire = in_tvalid & in_tready;

    always_comb begin
        state_next = state;
        pkt_end = 1'b0;
        in_tready_next = 1'b0;
        hdr_valid_next = hdr_valid & ~hdr_ready;
        cnt_clear = 1'b0;
        cnt_step = 1'b0;
        capture_en = 1'b0;
        sum_clear = 1'b0;
        sum_step = 1'b0;
        store_last = 1'b0;
        int_tdata = in_tdata;
        int_tvalid = 1'b0;
        int_tlast = in_tlast;
        int_tuser = in_tuser;
        hdr_early_next = 1'b0;
        pay_early_next = 1'b0;
        inv_hdr_next = 1'b0;
        inv_csum_next = 1'b0;

        case (state)
            IDLE, READ_HEADER: begin
                // a new packet waits until the last header was taken
                in_tready_next = (state == READ_HEADER) | ~hdr_valid;
                cnt_clear = (state == IDLE);
                sum_clear = (state == IDLE);
                if (in_fire) begin
                    cnt_clear = 1'b0;
                    sum_clear = 1'b0;
                    cnt_step = 1'b1;
                    sum_step = 1'b1;
                    capture_en = 1'b1;
                    state_next = READ_HEADER;
                    if (in_tlast) begin
                        hdr_early_next = 1'b1;
                        pkt_end = 1'b1;
                    end else if (hdr_last) begin
                        if (!hdr_fields_ok) begin
                            inv_hdr_next = 1'b1;
                            state_next = WAIT_LAST;
                        end else if (!sum_ok) begin
                            inv_csum_next = 1'b1;
                            state_next = WAIT_LAST;
                        end else begin
                            hdr_valid_next = 1'b1;
                            in_tready_next = int_tready_early;
                            state_next = READ_PAYLOAD;
                        end
                    end
                end
            end
            READ_PAYLOAD: begin
                in_tready_next = int_tready_early;
                int_tvalid = in_fire;
                if (in_fire) begin
                    cnt_step = 1'b1;
                    if (in_tlast) begin
                        // input ended short of the ip length
                        if (!payload_end) begin
                            int_tuser = 1'b1;
                            pay_early_next = 1'b1;
                        end
                        pkt_end = 1'b1;
                    end else if (payload_end) begin
                        // hold the last byte until tlast shows up
                        store_last = 1'b1;
                        int_tvalid = 1'b0;
                        state_next = READ_PAYLOAD_LAST;
                    end
                end
            end
            READ_PAYLOAD_LAST: begin
                // padding is dropped, only the final beat releases the held byte
                in_tready_next = int_tready_early;
                int_tdata = last_byte;
                int_tvalid = in_fire & in_tlast;
                pkt_end = in_fire & in_tlast;
            end
            WAIT_LAST: begin
                in_tready_next = 1'b1;
                pkt_end = in_fire & in_tlast;
            end
            default: state_next = IDLE;
        endcase

        if (pkt_end) begin
            cnt_clear = 1'b1;
            sum_clear = 1'b1;
            in_tready_next = ~hdr_valid;
            state_next = IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            in_tready <= 1'b0;
            hdr_valid <= 1'b0;
            error_header_early <= 1'b0;
            error_payload_early <= 1'b0;
            error_invalid_header <= 1'b0;
            error_invalid_checksum <= 1'b0;
        end else begin
            state <= state_next;
            in_tready <= in_tready_next;
            hdr_valid <= hdr_valid_next;
            error_header_early <= hdr_early_next;
            error_payload_early <= pay_early_next;
            error_invalid_header <= inv_hdr_next;
            error_invalid_checksum <= inv_csum_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_last) begin
            last_byte <= in_tdata;
        end
    end

    // a header never completes over one still waiting for hdr_ready
    a_hdr_not_overrun: assert property (@(posedge clk) disable iff (rst)
        (state == READ_HEADER && in_fire && hdr_last && !in_tlast) |-> !hdr_valid);

    a_idle_gate: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE && hdr_valid) |-> !in_tready);

    // counter must be back at zero for the first byte of a packet
    a_first_idx: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE && in_fire) |-> hdr_idx == '0);

endmodule

`default_nettype wire

/* hdl/axis_skid_buffer.sv */
// two-entry registered slice for a byte stream, ready to the source is registered
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire ip_rx_pkg::byte_t        int_tdata,
    input  wire                          int_tvalid,
    input  wire                          int_tlast,
    input  wire                          int_tuser,
    output logic                         int_tready_early,
    output ip_rx_pkg::byte_t             out_tdata,
    output logic                         out_tvalid,
    input  wire                          out_tready,
    output logic                         out_tlast,
    output logic                         out_tuser
);
    import ip_rx_pkg::*;

    logic  int_tready_reg;
    byte_t tmp_tdata;
    logic  tmp_tvalid;
    logic  tmp_tlast;
    logic  tmp_tuser;
    logic  out_tvalid_next;
    logic  tmp_tvalid_next;
    logic  int_to_out;
    logic  int_to_tmp;
    logic  tmp_to_out;

    // ready next cycle unless the temp entry could fill up
    assign int_tready_early = out_tready | (~tmp_tvalid & (~out_tvalid | ~int_tvalid));

    always_comb begin
        out_tvalid_next = out_tvalid;
        tmp_tvalid_next = tmp_tvalid;
        int_to_out = 1'b0;
        int_to_tmp = 1'b0;
        tmp_to_out = 1'b0;
        if (int_tready_reg) begin
            if (out_tready || !out_tvalid) begin
                out_tvalid_next = int_tvalid;
                int_to_out = 1'b1;
            end else begin
                tmp_tvalid_next = int_tvalid;
                int_to_tmp = 1'b1;
            end
        end else if (out_tready) begin
            // drain the temp entry
            out_tvalid_next = tmp_tvalid;
            tmp_tvalid_next = 1'b0;
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            int_tready_reg <= 1'b0;
            out_tvalid <= 1'b0;
            tmp_tvalid <= 1'b0;
        end else begin
            int_tready_reg <= int_tready_early;
            out_tvalid <= out_tvalid_next;
            tmp_tvalid <= tmp_tvalid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (int_to_out) begin
            {out_tdata, out_tlast, out_tuser} <= {int_tdata, int_tlast, int_tuser};
        end else if (tmp_to_out) begin
            {out_tdata, out_tlast, out_tuser} <= {tmp_tdata, tmp_tlast, tmp_tuser};
        end
        if (int_to_tmp) begin
            {tmp_tdata, tmp_tlast, tmp_tuser} <= {int_tdata, int_tlast, int_tuser};
        end
    end

    // the registered ready must have kept a full temp entry from being overwritten
    a_tmp_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        int_to_tmp |-> !tmp_tvalid);

endmodule

`default_nettype wire

/* hdl/ip_rx_top.sv */
// ipv4 receive parser top, byte stream in, header fields and payload stream out
`timescale 1ns/1ps
`default_nettype none
`include "ip_rx_params.svh"

module ip_rx_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire ip_rx_pkg::byte_t        in_tdata,
    input  wire                          in_tvalid,
    output wire                          in_tready,
    input  wire                          in_tlast,
    input  wire                          in_tuser,
    output wire                          hdr_valid,
    input  wire                          hdr_ready,
    output wire [5:0]                    ip_dscp,
    output wire [1:0]                    ip_ecn,
    output wire ip_rx_pkg::ip_len_t      ip_length,
    output wire ip_rx_pkg::ip_len_t      ip_identification,
    output wire [`IP_FLAGS_W-1:0]        ip_flags,
    output wire [`IP_FRAG_W-1:0]         ip_fragment_offset,
    output wire ip_rx_pkg::byte_t        ip_ttl,
    output wire ip_rx_pkg::byte_t        ip_protocol,
    output wire ip_rx_pkg::ip_len_t      ip_header_checksum,
    output wire ip_rx_pkg::ip_addr_t     ip_source_ip,
    output wire ip_rx_pkg::ip_addr_t     ip_dest_ip,
    output wire ip_rx_pkg::byte_t        out_tdata,
    output wire                          out_tvalid,
    input  wire                          out_tready,
    output wire                          out_tlast,
    output wire                          out_tuser,
    output wire                          error_header_early,
    output wire                          error_payload_early,
    output wire                          error_invalid_header,
    output wire                          error_invalid_checksum
);
    import ip_rx_pkg::*;

    // fsm to counter, capture and checksum
    logic     cnt_clear;
    logic     cnt_step;
    logic     capture_en;
    logic     sum_clear;
    logic     sum_step;
    hdr_idx_t hdr_idx;
    logic     hdr_last;
    logic     payload_end;
    logic     hdr_fields_ok;
    logic     sum_ok;

    // payload path into the skid buffer
    byte_t    int_tdata;
    logic     int_tvalid;
    logic     int_tlast;
    logic     int_tuser;
    logic     int_tready_early;

    ip_rx_fsm fsm0 (.*);

    ip_frame_counter counter0 (.*);

    ip_hdr_capture capture0 (.*);

    ip_hdr_checksum checksum0 (.*);

    axis_skid_buffer skid0 (.*);

endmodule

`default_nettype wire

/* bench/tb_ip_rx.sv */
// testbench for the ipv4 receive parser that applies a packet table under random back-pressure
`timescale 1ns/1ps
`default_nettype none

module tb_ip_rx;
    import ip_rx_pkg::*;

    localparam int WAIT_LIMIT = 5000;
    localparam int NUM_ROWS = 8;
    localparam logic [2:0] ERR_NONE = 3'd0;
    localparam logic [2:0] ERR_HDR_EARLY = 3'd1;
    localparam logic [2:0] ERR_PAY_EARLY = 3'd2;
    localparam logic [2:0] ERR_INV_HDR = 3'd3;
    localparam logic [2:0] ERR_INV_CSUM = 3'd4;

    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        ip_len_t     length;
        ip_len_t     ident;
        logic [2:0]  flags;
        logic [12:0] frag;
        byte_t       ttl;
        byte_t       proto;
        ip_len_t     csum;
        ip_addr_t    src;
        ip_addr_t    dst;
    } hdr_rec_t;

    // one packet with header, bytes sent, early tlast (8'hff for none), corruptions and error
    typedef struct packed {
        hdr_rec_t   hdr;
        ip_len_t    sent;
        logic [7:0] early_pos;
        logic       bad_ver;
        logic       bad_csum;
        logic       last_user;
        logic [2:0] err;
    } row_t;

    logic clk = 1'b0;
    logic rst = 1'b1;
    byte_t in_tdata;
    logic in_tvalid;
    logic in_tready;
    logic in_tlast;
    logic in_tuser;
    logic hdr_valid;
    logic hdr_ready;
    hdr_rec_t hdr_out;
    byte_t out_tdata;
    logic out_tvalid;
    logic out_tready;
    logic out_tlast;
    logic out_tuser;
    logic error_header_early;
    logic error_payload_early;
    logic error_invalid_header;
    logic error_invalid_checksum;

    row_t rows [0:NUM_ROWS-1];
    byte_t frame_q[$];
    hdr_rec_t hdr_q[$];
    logic [9:0] byte_q[$];
    int err_cnt [0:3];

    ip_rx_top dut0 (
        .clk(clk), .rst(rst),
        .in_tdata(in_tdata), .in_tvalid(in_tvalid), .in_tready(in_tready),
        .in_tlast(in_tlast), .in_tuser(in_tuser),
        .hdr_valid(hdr_valid), .hdr_ready(hdr_ready),
        .ip_dscp(hdr_out.dscp), .ip_ecn(hdr_out.ecn), .ip_length(hdr_out.length),
        .ip_identification(hdr_out.ident), .ip_flags(hdr_out.flags),
        .ip_fragment_offset(hdr_out.frag), .ip_ttl(hdr_out.ttl),
        .ip_protocol(hdr_out.proto), .ip_header_checksum(hdr_out.csum),
        .ip_source_ip(hdr_out.src), .ip_dest_ip(hdr_out.dst),
        .out_tdata(out_tdata), .out_tvalid(out_tvalid), .out_tready(out_tready),
        .out_tlast(out_tlast), .out_tuser(out_tuser),
        .error_header_early(error_header_early),
        .error_payload_early(error_payload_early),
        .error_invalid_header(error_invalid_header),
        .error_invalid_checksum(error_invalid_checksum)
    );

    always #4 clk = ~clk;

    // random back-pressure on both outputs
    always @(posedge clk) begin
        #1;
        out_tready = ($urandom % 4) != 0;
        hdr_ready = ($urandom % 2) != 0;
    end

    // monitors sample at the falling edge where everything is stable
    always @(negedge clk) begin
        if (!rst) begin
            if (out_tvalid && out_tready) begin
                byte_q.push_back({out_tdata, out_tlast, out_tuser});
            end
            if (hdr_valid && hdr_ready) begin
                hdr_q.push_back(hdr_out);
            end
            err_cnt[0] += int'(error_header_early);
            err_cnt[1] += int'(error_payload_early);
            err_cnt[2] += int'(error_invalid_header);
            err_cnt[3] += int'(error_invalid_checksum);
        end
    end

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_hdr(input hdr_rec_t got, input hdr_rec_t exp);
        if (got.dscp !== exp.dscp) report_value("ip_dscp", 32'(got.dscp), 32'(exp.dscp));
        if (got.ecn !== exp.ecn) report_value("ip_ecn", 32'(got.ecn), 32'(exp.ecn));
        if (got.length !== exp.length) report_value("ip_length", 32'(got.length), 32'(exp.length));
        if (got.ident !== exp.ident) report_value("ip_identification", 32'(got.ident), 32'(exp.ident));
        if (got.flags !== exp.flags) report_value("ip_flags", 32'(got.flags), 32'(exp.flags));
        if (got.frag !== exp.frag) report_value("ip_fragment_offset", 32'(got.frag), 32'(exp.frag));
        if (got.ttl !== exp.ttl) report_value("ip_ttl", 32'(got.ttl), 32'(exp.ttl));
        if (got.proto !== exp.proto) report_value("ip_protocol", 32'(got.proto), 32'(exp.proto));
        if (got.csum !== exp.csum) report_value("ip_header_checksum", 32'(got.csum), 32'(exp.csum));
        if (got.src !== exp.src) report_value("ip_source_ip", got.src, exp.src);
        if (got.dst !== exp.dst) report_value("ip_dest_ip", got.dst, exp.dst);
    endtask

    task automatic check_byte(input byte_t got_data, input logic got_last,
                              input logic got_user, input byte_t exp_data,
                              input logic exp_last, input logic exp_user);
        if (got_data !== exp_data) report_value("out_tdata", 32'(got_data), 32'(exp_data));
        if (got_last !== exp_last) report_value("out_tlast", 32'(got_last), 32'(exp_last));
        if (got_user !== exp_user) report_value("out_tuser", 32'(got_user), 32'(exp_user));
    endtask

    task automatic check_error(input logic [2:0] kind);
        int e;
        for (e = 1; e <= 4; e++) begin
            if (err_cnt[e-1] != int'(kind == 3'(e))) begin
                case (e)
                    1: report_value("error_header_early", err_cnt[0], 32'(kind == 3'd1));
                    2: report_value("error_payload_early", err_cnt[1], 32'(kind == 3'd2));
                    3: report_value("error_invalid_header", err_cnt[2], 32'(kind == 3'd3));
                    default: report_value("error_invalid_checksum", err_cnt[3], 32'(kind == 3'd4));
                endcase
            end
        end
    endtask

    function automatic row_t make_row(input hdr_rec_t hdr, input int sent, input int early,
                                      input logic bad_ver, input logic bad_csum,
                                      input logic last_user, input logic [2:0] err);
        row_t r;
        r.hdr = hdr;
        r.sent = ip_len_t'(sent);
        r.early_pos = 8'(early);
        r.bad_ver = bad_ver;
        r.bad_csum = bad_csum;
        r.last_user = last_user;
        r.err = err;
        return r;
    endfunction

    function automatic hdr_rec_t make_hdr(input int len, input int ident, input byte_t ttl,
                                          input ip_addr_t src, input ip_addr_t dst);
        hdr_rec_t h;
        h.dscp = 6'(ident);
        h.ecn = 2'(ident >> 6);
        h.length = ip_len_t'(len);
        h.ident = ip_len_t'(ident);
        h.flags = 3'b010;
        h.frag = 13'(ident * 3);
        h.ttl = ttl;
        h.proto = 8'h11;
        h.csum = '0;
        h.src = src;
        h.dst = dst;
        return h;
    endfunction

    task automatic load_table();
        rows[0] = make_row(make_hdr(40, 16'h1a2b, 8'h40, 32'hc0a80001, 32'hc0a80002),
                           40, 8'hff, 0, 0, 0, ERR_NONE);
        // padded frame whose final padding byte carries tuser
        rows[1] = make_row(make_hdr(30, 16'h0f3c, 8'h3f, 32'h0a000001, 32'h0a0000fe),
                           38, 8'hff, 0, 0, 1, ERR_NONE);
        rows[2] = make_row(make_hdr(60, 16'h7711, 8'h20, 32'hac100005, 32'hac100009),
                           35, 8'hff, 0, 0, 0, ERR_PAY_EARLY);
        rows[3] = make_row(make_hdr(40, 16'h2222, 8'h80, 32'h01020304, 32'h05060708),
                           40, 8'hff, 1, 0, 0, ERR_INV_HDR);
        rows[4] = make_row(make_hdr(21, 16'h5a5a, 8'h01, 32'hffffffff, 32'h00000000),
                           21, 8'hff, 0, 0, 0, ERR_NONE);
        rows[5] = make_row(make_hdr(28, 16'h3333, 8'h10, 32'h11223344, 32'h55667788),
                           28, 8'hff, 0, 1, 0, ERR_INV_CSUM);
        rows[6] = make_row(make_hdr(40, 16'h4444, 8'h22, 32'h99887766, 32'h55443322),
                           40, 12, 0, 0, 0, ERR_HDR_EARLY);
        rows[7] = make_row(make_hdr(64, 16'hbeef, 8'hff, 32'hdeadbeef, 32'hcafef00d),
                           70, 8'hff, 0, 0, 0, ERR_NONE);
    endtask

    // header bytes in network order followed by random payload up to the sent count
    task automatic build_frame(input row_t r, output ip_len_t csum);
        logic [31:0] acc;
        int i;
        frame_q.delete();
        frame_q.push_back({r.bad_ver ? 4'd6 : 4'd4, 4'd5});
        frame_q.push_back({r.hdr.dscp, r.hdr.ecn});
        frame_q.push_back(r.hdr.length[15:8]);
        frame_q.push_back(r.hdr.length[7:0]);
        frame_q.push_back(r.hdr.ident[15:8]);
        frame_q.push_back(r.hdr.ident[7:0]);
        frame_q.push_back({r.hdr.flags, r.hdr.frag[12:8]});
        frame_q.push_back(r.hdr.frag[7:0]);
        frame_q.push_back(r.hdr.ttl);
        frame_q.push_back(r.hdr.proto);
        frame_q.push_back(8'h00);
        frame_q.push_back(8'h00);
        for (i = 3; i >= 0; i--) frame_q.push_back(r.hdr.src[i*8 +: 8]);
        for (i = 3; i >= 0; i--) frame_q.push_back(r.hdr.dst[i*8 +: 8]);
        acc = 0;
        for (i = 0; i < 20; i += 2) acc += {16'h0, frame_q[i], frame_q[i+1]};
        acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};
        acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};
        csum = ~acc[15:0];
        if (r.bad_csum) csum = csum ^ 16'h0001;
        frame_q[10] = csum[15:8];
        frame_q[11] = csum[7:0];
        for (i = 20; i < int'(r.sent); i++) frame_q.push_back(byte_t'($urandom));
    endtask

    task automatic send_frame(input int tlast_pos, input logic last_user);
        int i;
        int waited;
        logic accepted;
        for (i = 0; i <= tlast_pos; i++) begin
            in_tdata = frame_q[i];
            in_tvalid = 1'b1;
            in_tlast = (i == tlast_pos);
            in_tuser = (i == tlast_pos) && last_user;
            waited = 0;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = in_tready;
                waited++;
                if (waited > WAIT_LIMIT) stop_run("input byte was never accepted");
            end
            @(posedge clk);
            #1;
        end
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
        in_tuser = 1'b0;
    endtask

    task automatic wait_done(input int n_hdr, input int n_bytes, input logic [2:0] kind);
        int waited;
        waited = 0;
        while (hdr_q.size() < n_hdr || byte_q.size() < n_bytes ||
               (kind != ERR_NONE && err_cnt[kind-1] == 0)) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) stop_run("timed out waiting for the packet results");
        end
    endtask

    task automatic run_row(input row_t r);
        ip_len_t csum;
        hdr_rec_t exp_hdr;
        logic [9:0] beat;
        int n_hdr;
        int n_bytes;
        int k;
        int tlast_pos;
        for (k = 0; k < 4; k++) err_cnt[k] = 0;
        build_frame(r, csum);
        exp_hdr = r.hdr;
        exp_hdr.csum = csum;
        n_hdr = (r.err == ERR_NONE || r.err == ERR_PAY_EARLY) ? 1 : 0;
        n_bytes = (r.err == ERR_NONE) ? int'(r.hdr.length) - 20 :
                  (r.err == ERR_PAY_EARLY) ? int'(r.sent) - 20 : 0;
        tlast_pos = (r.early_pos != 8'hff) ? int'(r.early_pos) : int'(r.sent) - 1;
        send_frame(tlast_pos, r.last_user);
        wait_done(n_hdr, n_bytes, r.err);
        if (hdr_q.size() != n_hdr) stop_run("unexpected header on the header output");
        if (byte_q.size() != n_bytes) stop_run("unexpected extra payload bytes");
        if (n_hdr == 1) check_hdr(hdr_q.pop_front(), exp_hdr);
        for (k = 0; k < n_bytes; k++) begin
            beat = byte_q.pop_front();
            check_byte(beat[9:2], beat[1], beat[0], frame_q[20 + k], k == n_bytes - 1,
                       (k == n_bytes - 1) && (r.err == ERR_PAY_EARLY || r.last_user));
        end
        check_error(r.err);
    endtask

    initial begin
        int r;
        void'($urandom(32'hef5d));
        in_tdata = '0;
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
        in_tuser = 1'b0;
        hdr_ready = 1'b0;
        out_tready = 1'b0;
        for (r = 0; r < 4; r++) err_cnt[r] = 0;
        load_table();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        // nothing may be left over once the outputs settle
        repeat (50) @(posedge clk);
        if (hdr_q.size() != 0 || byte_q.size() != 0) begin
            stop_run("output appeared after the last packet");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/ip_rx_pkg.sv
parser/ip_frame_counter.sv
parser/ip_hdr_capture.sv
parser/ip_hdr_checksum.sv
parser/ip_rx_fsm.sv
hdl/axis_skid_buffer.sv
hdl/ip_rx_top.sv
bench/tb_ip_rx.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ipv4 parser testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_ip_rx -o sim_ip_rx > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_ip_rx > sim.log 2>&1

grep -q "^STATUS: PASS$" sim.log && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }
